// ==== axis_pkt_fifo.f ====
rtl/axis_pkg.sv
rtl/fifo_pkg.sv
rtl/pkt_ram.sv
rtl/pkt_ingress.sv
rtl/pkt_egress.sv
rtl/axis_pkt_fifo.sv
bench/axis_pkt_fifo_tb.sv

// ==== bench/axis_pkt_fifo_tb.sv ====
// Packet FIFO testbench

`timescale 1ns/1ps

module axis_pkt_fifo_tb;

    localparam int DATA_BYTES  = 8;
    localparam int DEPTH       = 16;
    // Worst-case input beats over all tests
    localparam int MAX_BEATS   = 3 + 2 * 20 * 6 + 4 * 5 + 20 + 2;
    localparam int N_TESTS     = 6;
    localparam int CYCLE_LIMIT = 2 * MAX_BEATS + 200 * N_TESTS;

    // One stream beat, same field order as the output ports
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
        axis_pkg::id_t           id;
        axis_pkg::dest_t         dest;
        axis_pkg::user_t         user;
    } beat_t;

    logic clk_ifc;
    logic rst_n;
    logic in_tvalid, in_tready, in_tlast, in_overflow;
    logic [DATA_BYTES*8-1:0] in_tdata, out_tdata;
    logic [DATA_BYTES-1:0]   in_tkeep, out_tkeep;
    axis_pkg::id_t   in_tid, out_tid;
    axis_pkg::dest_t in_tdest, out_tdest;
    axis_pkg::user_t in_tuser, out_tuser;
    logic out_tready, out_tvalid, out_tlast;

    // Expected output beats, oldest first
    beat_t exp_q[$];
    string test_name;
    int transfers;
    int ovf_count;
    int ovf_base;
    int exp_drops;
    int cycles;
    // Beats written since reset, including the open packet
    int model_wr;
    // Output ready: 0 high, 1 random, 2 low
    int ready_mode;
    logic [31:0] stim_seed;
    logic [31:0] rdy_seed;

    axis_pkt_fifo #(
        .DATA_BYTES (DATA_BYTES),
        .DEPTH      (DEPTH)
    ) DUT (
        .clk_ifc, .rst_n,
        .in_tvalid, .in_tready, .in_tdata, .in_tkeep, .in_tlast,
        .in_tid, .in_tdest, .in_tuser,
        .out_tready, .out_tvalid, .out_tdata, .out_tkeep, .out_tlast,
        .out_tid, .out_tdest, .out_tuser,
        .in_overflow
    );

    always #5 clk_ifc = ~clk_ifc;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    ////////////////////
    // Compare tasks

    task automatic check_beat(input string name, input beat_t exp, input beat_t act);
        if (act !== exp) begin
            abort_run({$sformatf("ERR %s: expected data %h keep %h last %b id %h dest %h user %h",
                    name, exp.data, exp.keep, exp.last, exp.id, exp.dest, exp.user),
                $sformatf(", actual data %h keep %h last %b id %h dest %h user %h",
                    act.data, act.keep, act.last, act.id, act.dest, act.user)});
        end
    endtask

    task automatic check_drop(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("ERR %s: expected %0d overflow pulses, actual %0d",
                name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input string sig, input logic exp,
                               input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s: %s expected %b, actual %b", name, sig, exp, act));
        end
    endtask

    ////////////////////
    // Monitor and watchdog

    always @(posedge clk_ifc) begin : mon_out
        beat_t act;
        beat_t exp_b;
        if (rst_n) begin
            if (in_overflow) begin
                ovf_count++;
            end
            if (out_tvalid && out_tready) begin
                act = {out_tdata, out_tkeep, out_tlast, out_tid, out_tdest, out_tuser};
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("%s: output beat came out with no beat expected",
                        test_name));
                end else begin
                    exp_b = exp_q.pop_front();
                    check_beat(test_name, exp_b, act);
                end
                transfers++;
            end
        end
    end

    always @(posedge clk_ifc) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run($sformatf("Run timed out after %0d cycles", cycles));
        end
    end

    // Output ready pattern
    always @(negedge clk_ifc) begin
        if (ready_mode == 1) begin
            rdy_seed   = lcg_next(rdy_seed);
            out_tready = rdy_seed[20];
        end else begin
            out_tready = (ready_mode == 0);
        end
    end

    ////////////////////
    // Stimulus helpers

    // Mode changes on the rising edge, away from the ready driver
    task automatic set_ready(input int mode);
        @(posedge clk_ifc);
        ready_mode = mode;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        exp_drops = 0;
        ovf_base  = ovf_count;
    endtask

    // Drives one packet and predicts whether it is stored
    task automatic send_packet(input int len, input logic [DATA_BYTES-1:0] last_keep);
        beat_t pkt[$];
        beat_t b;
        int    loads;
        int    pkt_start;
        bit    dropping;
        pkt_start = model_wr;
        dropping  = 1'b0;
        for (int k = 0; k < len; k++) begin
            stim_seed = lcg_next(stim_seed);
            b.data[63:32] = stim_seed;
            stim_seed = lcg_next(stim_seed);
            b.data[31:0] = stim_seed;
            stim_seed = lcg_next(stim_seed);
            b.id   = stim_seed[19:16];
            b.dest = stim_seed[23:20];
            b.user = stim_seed[31:24];
            b.last = (k == len - 1);
            b.keep = b.last ? last_keep : '1;
            @(negedge clk_ifc);
            in_tvalid = 1'b1;
            in_tdata  = b.data;
            in_tkeep  = b.keep;
            in_tlast  = b.last;
            in_tid    = b.id;
            in_tdest  = b.dest;
            in_tuser  = b.user;
            while (!in_tready) @(negedge clk_ifc);
            // Read pointer = beats taken plus the one held at the output
            loads = transfers + int'(out_tvalid);
            if (!dropping && (model_wr - loads) < DEPTH) begin
                pkt.push_back(b);
                model_wr++;
            end else begin
                // No room, whole packet goes
                dropping = 1'b1;
                model_wr = pkt_start;
            end
        end
        if (dropping) begin
            exp_drops++;
        end else begin
            foreach (pkt[i]) exp_q.push_back(pkt[i]);
        end
    endtask

    task automatic send_random(input int n);
        int len;
        repeat (n) begin
            stim_seed = lcg_next(stim_seed);
            len = 1 + int'(stim_seed[18:16]) % 6;
            send_packet(len, {DATA_BYTES{1'b1}} >> stim_seed[22:20]);
        end
    endtask

    task automatic end_input();
        @(negedge clk_ifc);
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        end_input();
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            @(negedge clk_ifc);
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%s: %0d expected beats never came out of the FIFO",
                test_name, exp_q.size()));
        end
        // Late pulse or stray beat shows up here
        repeat (8) @(negedge clk_ifc);
    endtask

    ////////////////////
    // Directed tests

    task automatic test_reset();
        begin_test("test_reset");
        repeat (3) begin
            @(posedge clk_ifc);
            @(negedge clk_ifc);
            check_level(test_name, "out_tvalid", 1'b0, out_tvalid);
            check_level(test_name, "in_tready", 1'b0, in_tready);
            check_level(test_name, "in_overflow", 1'b0, in_overflow);
        end
        rst_n = 1'b1;
        // First edge after release still sees in_tready low
        check_level(test_name, "in_tready", 1'b0, in_tready);
        @(negedge clk_ifc);
        check_level(test_name, "in_tready", 1'b1, in_tready);
        check_level(test_name, "out_tvalid", 1'b0, out_tvalid);
        check_level(test_name, "in_overflow", 1'b0, in_overflow);
    endtask

    task automatic test_single_packet();
        begin_test("test_single_packet");
        set_ready(0);
        send_packet(3, 8'h0f);
        wait_drain();
        check_drop(test_name, 0, ovf_count - ovf_base);
    endtask

    task automatic test_back_to_back();
        begin_test("test_back_to_back");
        stim_seed = 32'haffe;
        set_ready(0);
        send_random(20);
        wait_drain();
        check_drop(test_name, 0, ovf_count - ovf_base);
    endtask

    task automatic test_backpressure();
        begin_test("test_backpressure");
        // Replay the back-to-back traffic
        stim_seed = 32'haffe;
        set_ready(1);
        send_random(20);
        wait_drain();
        set_ready(0);
        check_drop(test_name, exp_drops, ovf_count - ovf_base);
        $display("%s: %0d packets dropped", test_name, exp_drops);
    endtask

    task automatic test_fill_drop();
        begin_test("test_fill_drop");
        set_ready(2);
        repeat (4) send_packet(5, '1);
        end_input();
        repeat (4) @(negedge clk_ifc);
        // Three packets fit, the fourth does not
        check_drop(test_name, 1, ovf_count - ovf_base);
        set_ready(0);
        wait_drain();
        check_drop(test_name, 1, ovf_count - ovf_base);
    endtask

    task automatic test_oversize_drop();
        begin_test("test_oversize_drop");
        set_ready(0);
        send_packet(20, '1);
        send_packet(2, 8'h3f);
        wait_drain();
        check_drop(test_name, 1, ovf_count - ovf_base);
    endtask

    initial begin
        clk_ifc    = 1'b0;
        rst_n      = 1'b0;
        in_tvalid  = 1'b0;
        in_tdata   = '0;
        in_tkeep   = '0;
        in_tlast   = 1'b0;
        in_tid     = '0;
        in_tdest   = '0;
        in_tuser   = '0;
        out_tready = 1'b0;
        ready_mode = 0;
        transfers  = 0;
        ovf_count  = 0;
        cycles     = 0;
        model_wr   = 0;
        stim_seed  = 32'haffe;
        rdy_seed   = lcg_next(32'haffe);
        test_reset();
        test_single_packet();
        test_back_to_back();
        test_backpressure();
        test_fill_drop();
        test_oversize_drop();
        if (exp_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run("Expected beats left over at the end of the run");
        end
    end

endmodule

// ==== rtl/axis_pkg.sv ====
// Stream beat sideband definitions

package axis_pkg;

    ////////////////////
    // Sideband widths

    // Stream id
    localparam int ID_W   = 4;
    // Routing destination
    localparam int DEST_W = 4;
    // User sideband
    localparam int USER_W = 8;

    // All sideband bits of one beat
    localparam int SIDE_W = ID_W + DEST_W + USER_W;

    ////////////////////
    // Sideband types

    typedef logic [ID_W-1:0]   id_t;
    typedef logic [DEST_W-1:0] dest_t;
    typedef logic [USER_W-1:0] user_t;

    // Stored word: data, keep, last and sideband
    function automatic int word_w(input int data_bytes);
        return data_bytes * 9 + 1 + SIDE_W;
    endfunction

endpackage

// ==== rtl/axis_pkt_fifo.sv ====
// Store-and-forward packet FIFO
// Ingress, RAM and egress

`timescale 1ns/1ps

module axis_pkt_fifo #(
    parameter int DATA_BYTES = 8,
    parameter int DEPTH      = 16
) (
    input  logic                    clk_ifc,
    input  logic                    rst_n,
    // Input stream
    input  logic                    in_tvalid,
    output logic                    in_tready,
    input  logic [DATA_BYTES*8-1:0] in_tdata,
    input  logic [DATA_BYTES-1:0]   in_tkeep,
    input  logic                    in_tlast,
    input  axis_pkg::id_t           in_tid,
    input  axis_pkg::dest_t         in_tdest,
    input  axis_pkg::user_t         in_tuser,
    // Output stream
    input  logic                    out_tready,
    output logic                    out_tvalid,
    output logic [DATA_BYTES*8-1:0] out_tdata,
    output logic [DATA_BYTES-1:0]   out_tkeep,
    output logic                    out_tlast,
    output axis_pkg::id_t           out_tid,
    output axis_pkg::dest_t         out_tdest,
    output axis_pkg::user_t         out_tuser,
    // Dropped packet pulse
    output logic                    in_overflow
);

    localparam int PTR_W  = fifo_pkg::ptr_w(DEPTH);
    localparam int WORD_W = axis_pkg::word_w(DATA_BYTES);

    ////////////////////
    // Internal wires

    logic              wr_en;
    logic [PTR_W-2:0]  wr_addr;
    logic [WORD_W-1:0] wr_word;
    logic [PTR_W-2:0]  rd_addr;
    logic [WORD_W-1:0] rd_word;
    // Pointer exchange between the two sides
    logic [PTR_W-1:0]  commit_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    ////////////////////
    // Blocks

    pkt_ingress #(
        .DATA_BYTES (DATA_BYTES),
        .DEPTH      (DEPTH)
    ) u_ingress (
        .clk_ifc,
        .rst_n,
        .in_tvalid,
        .in_tready,
        .in_tdata,
        .in_tkeep,
        .in_tlast,
        .in_tid,
        .in_tdest,
        .in_tuser,
        .rd_ptr,
        .wr_en,
        .wr_addr,
        .wr_word,
        .commit_ptr,
        .in_overflow
    );

    pkt_ram #(
        .DATA_BYTES (DATA_BYTES),
        .DEPTH      (DEPTH)
    ) u_ram (
        .clk_ifc,
        .wr_en,
        .wr_addr,
        .wr_word,
        .rd_addr,
        .rd_word
    );

    pkt_egress #(
        .DATA_BYTES (DATA_BYTES),
        .DEPTH      (DEPTH)
    ) u_egress (
        .clk_ifc,
        .rst_n,
        .commit_ptr,
        .rd_ptr,
        .rd_addr,
        .rd_word,
        .out_tready,
        .out_tvalid,
        .out_tdata,
        .out_tkeep,
        .out_tlast,
        .out_tid,
        .out_tdest,
        .out_tuser
    );

endmodule

// ==== rtl/fifo_pkg.sv ====
// Packet FIFO control definitions

package fifo_pkg;

    ////////////////////
    // Ingress FSM

    // IDLE between packets, PASS while storing, DROP while discarding
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_PASS = 2'd1,
        WR_DROP = 2'd2
    } wr_state_e;

    ////////////////////
    // Pointer helpers

    // Address bits plus one wrap bit, so full and empty differ
    function automatic int ptr_w(input int depth);
        return $clog2(depth) + 1;
    endfunction

endpackage

// ==== rtl/pkt_egress.sv ====
// Packet FIFO read control

`timescale 1ns/1ps

module pkt_egress #(
    parameter  int DATA_BYTES = 8,
    parameter  int DEPTH      = 16,
    localparam int PTR_W      = fifo_pkg::ptr_w(DEPTH),
    localparam int WORD_W     = axis_pkg::word_w(DATA_BYTES)
) (
    input  logic                    clk_ifc,
    input  logic                    rst_n,
    // Committed boundary from ingress
    input  logic [PTR_W-1:0]        commit_ptr,
    output logic [PTR_W-1:0]        rd_ptr,
    // RAM read port
    output logic [PTR_W-2:0]        rd_addr,
    input  logic [WORD_W-1:0]       rd_word,
    // Output stream
    input  logic                    out_tready,
    output logic                    out_tvalid,
    output logic [DATA_BYTES*8-1:0] out_tdata,
    output logic [DATA_BYTES-1:0]   out_tkeep,
    output logic                    out_tlast,
    output axis_pkg::id_t           out_tid,
    output axis_pkg::dest_t         out_tdest,
    output axis_pkg::user_t         out_tuser
);

    localparam logic [PTR_W-1:0] DEPTH_P = PTR_W'(DEPTH);

    logic has_data;
    logic load;

    ////////////////////
    // Read side

    // Anything between rd_ptr and commit_ptr is a complete packet
    assign has_data = commit_ptr != rd_ptr;

    // Register empty, or its beat leaves this cycle
    assign load = has_data && (!out_tvalid || out_tready);

    assign rd_addr = rd_ptr[PTR_W-2:0];

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            out_tvalid <= 1'b0;
        end else begin
            if (load) begin
                rd_ptr     <= rd_ptr + 1'b1;
                out_tvalid <= 1'b1;
            end else if (out_tready) begin
                // Beat taken and nothing behind it
                out_tvalid <= 1'b0;
            end
        end
    end

    ////////////////////
    // Output register

    // Same layout as the ingress write word
    always_ff @(posedge clk_ifc) begin
        if (load) begin
            {out_tuser, out_tdest, out_tid, out_tlast, out_tkeep, out_tdata} <= rd_word;
        end
    end

    ////////////////////
    // Checks

    // Beat held under back-pressure
    a_out_stable: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        out_tvalid && !out_tready |=> out_tvalid &&
            $stable({out_tdata, out_tkeep, out_tlast, out_tid, out_tdest, out_tuser})
    );

    // Reader stays within the committed region
    a_rd_le_commit: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        (commit_ptr - rd_ptr) <= DEPTH_P
    );

endmodule

// ==== rtl/pkt_ingress.sv ====
// Packet FIFO write control

`timescale 1ns/1ps

module pkt_ingress #(
    parameter  int DATA_BYTES = 8,
    parameter  int DEPTH      = 16,
    localparam int PTR_W      = fifo_pkg::ptr_w(DEPTH),
    localparam int WORD_W     = axis_pkg::word_w(DATA_BYTES)
) (
    input  logic                    clk_ifc,
    input  logic                    rst_n,
    // Input stream
    input  logic                    in_tvalid,
    output logic                    in_tready,
    input  logic [DATA_BYTES*8-1:0] in_tdata,
    input  logic [DATA_BYTES-1:0]   in_tkeep,
    input  logic                    in_tlast,
    input  axis_pkg::id_t           in_tid,
    input  axis_pkg::dest_t         in_tdest,
    input  axis_pkg::user_t         in_tuser,
    // Read pointer from egress, for free space
    input  logic [PTR_W-1:0]        rd_ptr,
    // RAM write port
    output logic                    wr_en,
    output logic [PTR_W-2:0]        wr_addr,
    output logic [WORD_W-1:0]       wr_word,
    // End of last committed packet
    output logic [PTR_W-1:0]        commit_ptr,
    // One pulse per dropped packet
    output logic                    in_overflow
);

    localparam logic [PTR_W-1:0] DEPTH_P = PTR_W'(DEPTH);

    fifo_pkg::wr_state_e state;

    // Speculative pointer, runs ahead of commit_ptr
    logic [PTR_W-1:0] wr_ptr;
    // Last beat written on the previous edge
    logic             commit_pend;

    logic             beat_acc;
    logic             has_room;
    logic             pass_beat;
    logic [PTR_W-1:0] used;
    logic [PTR_W-1:0] rewind_ptr;

    ////////////////////
    // Free space

    assign beat_acc = in_tvalid && in_tready;

    // Uncommitted beats count as used
    assign used     = wr_ptr - rd_ptr;
    assign has_room = used < DEPTH_P;

    // Beat goes to RAM only while the packet still fits
    assign pass_beat = beat_acc && (state != fifo_pkg::WR_DROP) && has_room;

    // Commit still in flight, so wr_ptr already holds the boundary
    assign rewind_ptr = commit_pend ? wr_ptr : commit_ptr;

    ////////////////////
    // RAM write

    assign wr_en   = pass_beat;
    assign wr_addr = wr_ptr[PTR_W-2:0];
    // Layout unpacked again in egress
    assign wr_word = {in_tuser, in_tdest, in_tid, in_tlast, in_tkeep, in_tdata};

    ////////////////////
    // Write FSM

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state       <= fifo_pkg::WR_IDLE;
            wr_ptr      <= '0;
            commit_ptr  <= '0;
            commit_pend <= 1'b0;
            in_overflow <= 1'b0;
            in_tready   <= 1'b0;
        end else begin
            // Ready from the second edge on, never drops again
            in_tready   <= 1'b1;
            in_overflow <= 1'b0;
            commit_pend <= 1'b0;

            // Publish packet one cycle after its last write
            if (commit_pend) begin
                commit_ptr <= wr_ptr;
            end

            if (beat_acc) begin
                if (pass_beat) begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (in_tlast) begin
                        state       <= fifo_pkg::WR_IDLE;
                        commit_pend <= 1'b1;
                    end else begin
                        state <= fifo_pkg::WR_PASS;
                    end
                end else begin
                    // Out of room, discard what was written so far
                    if (state != fifo_pkg::WR_DROP) begin
                        wr_ptr <= rewind_ptr;
                    end
                    if (in_tlast) begin
                        state       <= fifo_pkg::WR_IDLE;
                        in_overflow <= 1'b1;
                    end else begin
                        state <= fifo_pkg::WR_DROP;
                    end
                end
            end
        end
    end

    ////////////////////
    // Checks

    // Egress read pointer never falls behind a full FIFO
    a_used_le_depth: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        used <= DEPTH_P
    );

    // Commit lands two edges after an accepted last beat
    a_commit_on_last: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        !$stable(commit_ptr) |-> $past(in_tvalid && in_tready && in_tlast, 2)
    );

    // Drop reported once per packet
    // Second cycle high only for a second dropped last beat
    a_overflow_pulse: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        in_overflow |=> !in_overflow || $past(in_tvalid && in_tready && in_tlast)
    );

endmodule

// ==== rtl/pkt_ram.sv ====
// Packet storage RAM

`timescale 1ns/1ps

module pkt_ram #(
    parameter  int DATA_BYTES = 8,
    parameter  int DEPTH      = 16,
    localparam int PTR_W      = fifo_pkg::ptr_w(DEPTH),
    localparam int WORD_W     = axis_pkg::word_w(DATA_BYTES)
) (
    input  logic              clk_ifc,
    // Write port, driven by ingress
    input  logic              wr_en,
    input  logic [PTR_W-2:0]  wr_addr,
    input  logic [WORD_W-1:0] wr_word,
    // Read port, driven by egress
    input  logic [PTR_W-2:0]  rd_addr,
    output logic [WORD_W-1:0] rd_word
);

    // Pointers wrap on the address bits only
    if (DEPTH < 4 || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
        $error("pkt_ram: DEPTH must be a power of two of at least 4");
    end

    ////////////////////
    // Storage array

    // One word per beat
    logic [WORD_W-1:0] mem [DEPTH];

    // Synchronous write
    always_ff @(posedge clk_ifc) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // Asynchronous read, maps onto distributed RAM
    // Egress registers the result itself
    assign rd_word = mem[rd_addr];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the packet FIFO testbench with Verilator

set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

verilator --binary --assert -Wno-fatal \
    --top-module axis_pkt_fifo_tb \
    -Mdir obj_dir \
    -f axis_pkt_fifo.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vaxis_pkt_fifo_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
